//--- list.f
x86_pkg.sv
decode_pkg.sv
opcode_control.sv
disp_decode.sv
ea_select.sv
operand_select.sv
decode_top.sv
tb_decode.sv

//--- Makefile
.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/Vtb_decode)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

build:
	verilator --binary --timing --assert --top-module tb_decode -f list.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module tb_decode -f list.f
	verilator --lint-only -Wall --top-module decode_top x86_pkg.sv decode_pkg.sv \
		opcode_control.sv disp_decode.sv ea_select.sv operand_select.sv decode_top.sv

clean:
	rm -rf obj_dir

//--- tb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode;

    localparam int STIM_CYCLES    = 32 * 30 + 32 + 2 * 256;
    localparam int TIMEOUT_CYCLES = 3 * STIM_CYCLES;    // Leaves room for idle gaps

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    in_valid;
    x86_pkg::opcode_t        opcode;
    x86_pkg::modrm_t         modrm;
    logic                    out_valid;
    decode_pkg::decode_out_t dec;

    decode_pkg::decode_out_t expected[$];       // Records in flight
    decode_pkg::decode_out_t exp_now = '0;      // Record due at the next sampled pulse
    logic                    rst_seen = 1'b0;
    logic                    any_out = 1'b0;
    int                      value_errors = 0;
    int                      protocol_errors = 0;
    int                      cycles = 0;

    decode_top uut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .opcode    (opcode),
        .modrm     (modrm),
        .out_valid (out_valid),
        .dec       (dec)
    );

    always #20 clk = ~clk;

    function automatic x86_pkg::modrm_t rand_byte();
        logic [31:0] v;
        v = $urandom;
        return v[7:0];
    endfunction

    // 8086 addressing table
    function automatic decode_pkg::ea_t expect_ea(input logic [1:0] md, input logic [2:0] rm);
        case (rm)
            3'd0: return {x86_pkg::REG_BX, x86_pkg::REG_SI, x86_pkg::SEG_DS};
            3'd1: return {x86_pkg::REG_BX, x86_pkg::REG_DI, x86_pkg::SEG_DS};
            3'd2: return {x86_pkg::REG_BP, x86_pkg::REG_SI, x86_pkg::SEG_SS};
            3'd3: return {x86_pkg::REG_BP, x86_pkg::REG_DI, x86_pkg::SEG_SS};
            3'd4: return {x86_pkg::NO_REG, x86_pkg::REG_SI, x86_pkg::SEG_DS};
            3'd5: return {x86_pkg::NO_REG, x86_pkg::REG_DI, x86_pkg::SEG_DS};
            3'd6: return (md == 2'b00) ? {x86_pkg::NO_REG, x86_pkg::NO_REG, x86_pkg::SEG_DS}
                                       : {x86_pkg::REG_BP, x86_pkg::NO_REG, x86_pkg::SEG_SS};
            default: return {x86_pkg::REG_BX, x86_pkg::NO_REG, x86_pkg::SEG_DS};
        endcase
    endfunction

    // Reference decode of one byte pair
    function automatic decode_pkg::decode_out_t expect_rec(input logic [7:0] op,
                                                           input x86_pkg::modrm_t m);
        decode_pkg::decode_out_t r;
        logic       uses_modrm;
        logic       always_disp;
        logic       direct;
        logic       force16;
        logic [2:0] d_fld;
        logic [2:0] s_fld;
        r           = '0;
        uses_modrm  = 1'b0;
        always_disp = 1'b0;
        direct      = (m.mod == 2'b00) && (m.rm == 3'b110);
        force16     = (op[7:2] == 6'b101000) || op == 8'h9A || op == 8'hEA;  // 16-bit offsets
        d_fld       = op[1] ? m.regm : m.rm;    // D bit
        s_fld       = op[1] ? m.rm : m.regm;
        if ((op[7:6] == 2'b00 && op[2] == 1'b0) || op[7:2] == 6'b100001
            || op[7:2] == 6'b100010)
        begin
            uses_modrm = 1'b1;  // ALU, TEST, XCHG and MOV R/M R
            r.dst      = {1'b0, d_fld};
            r.src      = {1'b0, s_fld};
        end
        else if ((op[7:6] == 2'b00 && op[2:1] == 2'b10) || op[7:1] == 7'b1010100)
        begin
            r.need_imm = 1'b1;
            r.imm_size = op[0];
        end
        else if (op[7:4] == 4'h7 || op[7:2] == 6'b101000)
            always_disp = 1'b1;
        else if (op[7:2] == 6'b100000)
        begin
            uses_modrm = 1'b1;
            r.need_imm = 1'b1;
            r.imm_size = (op == 8'h81);
            r.dst      = {1'b0, m.rm};
        end
        else if (op == 8'h8C || op == 8'h8E)
        begin
            uses_modrm = 1'b1;
            r.dst      = {op[1], d_fld};
            r.src      = {~op[1], s_fld};
        end
        else if (op == 8'h8D || op == 8'h8F)
        begin
            uses_modrm = 1'b1;
            r.dst      = {1'b0, m.rm};
        end
        else if (op[7:3] == 5'b10010)
            r.src = {1'b0, op[2:0]};
        else if (op == 8'h9A || op == 8'hEA)
        begin
            always_disp = 1'b1;
            r.need_imm  = 1'b1;
            r.imm_size  = 1'b1;
        end
        else if (op[7:4] == 4'hB)
        begin
            r.need_imm = 1'b1;
            r.imm_size = op[3];
            r.dst      = {1'b0, op[2:0]};
        end
        else if (op[7:1] == 7'b1100000 || op[7:1] == 7'b1100011)
        begin
            uses_modrm = 1'b1;  // Shift group and MOV IMM to R/M
            r.need_imm = 1'b1;
            r.imm_size = op[1] & op[0];
            r.dst      = {1'b0, m.rm};
            r.src      = op[1] ? 4'h0 : {1'b0, m.rm};
        end
        else if (op[7:1] == 7'b1100010)
        begin
            uses_modrm = 1'b1;
            r.src      = {1'b0, s_fld};
        end
        else
            return '0;
        r.byte_word  = (op[7:4] == 4'hB || op[7:2] == 6'b100011) ? op[3] : op[0];
        r.need_modrm = uses_modrm;
        if (always_disp)
        begin
            r.need_disp = 1'b1;
            r.disp_size = force16;
        end
        else if (uses_modrm && (direct || m.mod == 2'b01 || m.mod == 2'b10))
        begin
            r.need_disp = 1'b1;
            r.disp_size = force16 | direct | m.mod[1];
        end
        if (uses_modrm)
            r.ea = expect_ea(m.mod, m.rm);
        return r;
    endfunction

    task automatic report_diff(input decode_pkg::decode_out_t got,
                               input decode_pkg::decode_out_t exp);
        value_errors++;
        if (got.need_modrm != exp.need_modrm)
            $display("Fail dec.need_modrm: got %h expected %h", got.need_modrm, exp.need_modrm);
        if (got.need_disp != exp.need_disp)
            $display("Fail dec.need_disp: got %h expected %h", got.need_disp, exp.need_disp);
        if (got.disp_size != exp.disp_size)
            $display("Fail dec.disp_size: got %h expected %h", got.disp_size, exp.disp_size);
        if (got.need_imm != exp.need_imm)
            $display("Fail dec.need_imm: got %h expected %h", got.need_imm, exp.need_imm);
        if (got.imm_size != exp.imm_size)
            $display("Fail dec.imm_size: got %h expected %h", got.imm_size, exp.imm_size);
        if (got.byte_word != exp.byte_word)
            $display("Fail dec.byte_word: got %h expected %h", got.byte_word, exp.byte_word);
        if (got.src != exp.src || got.dst != exp.dst)
            $display("Fail dec.src/dst: got %h/%h expected %h/%h", got.src, got.dst,
                     exp.src, exp.dst);
        if (got.ea != exp.ea)
            $display("Fail dec.ea: got %h expected %h", got.ea, exp.ea);
    endtask

    task automatic send(input x86_pkg::opcode_t op, input x86_pkg::modrm_t mrm);
        in_valid = 1'b1;
        opcode   = op;
        modrm    = mrm;
        expected.push_back(expect_rec(op, mrm));
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        if ($urandom_range(3) == 0)
        begin
            @(posedge clk);     // Idle gap now and then
            #2;
        end
    endtask

    // Queue head lines up with the pulse sampled at the next rising edge
    always @(negedge clk)
    begin
        if (reset)
            rst_seen = 1'b1;
        if (out_valid)
        begin
            any_out = 1'b1;
            if (expected.size() != 0)
                exp_now = expected.pop_front();
        end
    end

    a_record: assert property (@(posedge clk) out_valid |-> dec == exp_now)
        else report_diff($sampled(dec), $sampled(exp_now));

    a_pulse: assert property (@(posedge clk) rst_seen |-> out_valid == $past(in_valid, 2))
        else
        begin
            protocol_errors++;
            $display("out_valid was %0d where in_valid two edges earlier calls for %0d",
                     $sampled(out_valid), !$sampled(out_valid));
        end

    a_idle_zero: assert property (@(posedge clk)
        rst_seen && !any_out && !out_valid |-> dec == '0)
        else
        begin
            value_errors++;
            $display("Fail dec: got %h expected 0", $sampled(dec));
        end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, %0d records never came out", cycles,
                     expected.size());
            $display("Simulation failed");
            $finish;
        end
    end

    initial
    begin
        x86_pkg::modrm_t mrm;
        reset    = 1'b1;
        in_valid = 1'b0;
        opcode   = '0;
        modrm    = '0;
        void'($urandom(11));
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int op = 0; op < 64; op++)     // ALU R/M R forms
            if (op[2] == 1'b0)
                for (int n = 0; n < 30; n++)
                    send(op[7:0], rand_byte());
        for (int md = 0; md < 4; md++)      // Whole addressing table
            for (int rm = 0; rm < 8; rm++)
            begin
                mrm     = rand_byte();
                mrm.mod = md[1:0];
                mrm.rm  = rm[2:0];
                send(8'h02, mrm);
            end
        for (int op = 0; op < 256; op++)
        begin
            mrm     = rand_byte();
            mrm.mod = 2'b11;
            send(op[7:0], mrm);
        end
        for (int op = 0; op < 256; op++)
        begin
            mrm     = rand_byte();
            mrm.mod = 2'($urandom_range(2));    // Memory forms
            send(op[7:0], mrm);
        end
        while (expected.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  x86_pkg::opcode_t        opcode,
    input  x86_pkg::modrm_t         modrm,
    output logic                    out_valid,
    output decode_pkg::decode_out_t dec
);

    x86_pkg::opcode_t         opcode_q;
    x86_pkg::modrm_t          modrm_q;
    logic                     cap_valid;    // Byte pair waiting in the capture regs
    decode_pkg::decode_ctrl_t ctrl;
    logic                     need_disp;
    logic                     disp_size;
    decode_pkg::ea_t          ea;
    x86_pkg::reg_id_t         src;
    x86_pkg::reg_id_t         dst;
    decode_pkg::decode_out_t  rec;

    opcode_control u_ctrl (.opcode(opcode_q), .ctrl(ctrl));

    disp_decode u_disp (
        .ctrl      (ctrl),
        .modrm     (modrm_q),
        .need_disp (need_disp),
        .disp_size (disp_size)
    );

    ea_select u_ea (.mod(modrm_q.mod), .rm(modrm_q.rm), .ea(ea));

    operand_select u_opnd (
        .ctrl   (ctrl),
        .opcode (opcode_q),
        .modrm  (modrm_q),
        .src    (src),
        .dst    (dst)
    );

    always_comb
    begin
        rec.need_modrm = ctrl.need_modrm;
        rec.need_disp  = need_disp;
        rec.disp_size  = disp_size;
        rec.need_imm   = ctrl.need_imm;
        rec.imm_size   = ctrl.imm_size;
        rec.byte_word  = ctrl.byte_word;
        rec.src        = src;
        rec.dst        = dst;
        rec.ea         = ctrl.need_modrm ? ea : '0;    // No address without ModR/M
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            opcode_q <= opcode;
            modrm_q  <= modrm;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cap_valid <= 1'b0;
            out_valid <= 1'b0;
            dec       <= '0;
        end
        else
        begin
            cap_valid <= in_valid;
            out_valid <= cap_valid;
            if (cap_valid)
                dec <= rec;     // Held until the next record
        end
    end

    a_imm_size: assert property (@(posedge clk) disable iff (reset)
        !dec.need_imm |-> !dec.imm_size)
        else $error("imm_size set without an immediate");

    // Shift group keeps the ModR/M rule in its register form
    a_reg_no_disp: assert property (@(posedge clk) disable iff (reset)
        cap_valid && ctrl.need_modrm && modrm_q.mod == x86_pkg::MOD_REG
        && opcode_q[7:1] != 7'b1100_000 |=> !dec.need_disp)
        else $error("displacement flagged for a register operand");

    a_back_to_back: assert property (@(posedge clk) disable iff (reset)
        out_valid && $past(out_valid) |-> $past(in_valid, 2) && $past(in_valid, 3))
        else $error("out_valid on two edges without two in_valid strobes");

endmodule

`default_nettype wire

//--- operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  decode_pkg::decode_ctrl_t ctrl,
    input  x86_pkg::opcode_t         opcode,
    input  x86_pkg::modrm_t          modrm,
    output x86_pkg::reg_id_t         src,
    output x86_pkg::reg_id_t         dst
);

    // Register number picked by a selector
    function automatic logic [2:0] pick_field(
        input decode_pkg::opnd_sel_t sel,
        input x86_pkg::opcode_t      op,
        input x86_pkg::modrm_t       mrm
    );
        case (sel)
            decode_pkg::OPND_REGM:  return mrm.regm;
            decode_pkg::OPND_RM:    return mrm.rm;
            decode_pkg::OPND_DIR_D: return op[1] ? mrm.regm : mrm.rm;   // D bit
            decode_pkg::OPND_DIR_S: return op[1] ? mrm.rm : mrm.regm;
            decode_pkg::OPND_OPC:   return op[2:0];
            default:                return 3'b000;
        endcase
    endfunction

    logic dst_seg;
    logic src_seg;

    // MOV sreg: 8E writes a segment register, 8C reads one
    assign dst_seg = ctrl.sreg_dir & opcode[1];
    assign src_seg = ctrl.sreg_dir & ~opcode[1];

    assign dst = {dst_seg, pick_field(ctrl.dst_sel, opcode, modrm)};
    assign src = {src_seg, pick_field(ctrl.src_sel, opcode, modrm)};

endmodule

`default_nettype wire

//--- ea_select.sv
`timescale 1ns/1ps
`default_nettype none

module ea_select (
    input  logic [1:0]        mod,
    input  logic [2:0]        rm,
    output decode_pkg::ea_t   ea
);

    // 8086 addressing table
    always_comb
    begin
        case (rm)
            3'b000: ea = '{x86_pkg::REG_BX, x86_pkg::REG_SI, x86_pkg::SEG_DS};
            3'b001: ea = '{x86_pkg::REG_BX, x86_pkg::REG_DI, x86_pkg::SEG_DS};
            3'b010: ea = '{x86_pkg::REG_BP, x86_pkg::REG_SI, x86_pkg::SEG_SS};
            3'b011: ea = '{x86_pkg::REG_BP, x86_pkg::REG_DI, x86_pkg::SEG_SS};
            3'b100: ea = '{x86_pkg::NO_REG, x86_pkg::REG_SI, x86_pkg::SEG_DS};
            3'b101: ea = '{x86_pkg::NO_REG, x86_pkg::REG_DI, x86_pkg::SEG_DS};
            3'b110:
            begin
                if (mod == 2'b00)
                begin
                    // Direct address, only the displacement
                    ea = '{x86_pkg::NO_REG, x86_pkg::NO_REG, x86_pkg::SEG_DS};
                end
                else
                begin
                    ea = '{x86_pkg::REG_BP, x86_pkg::NO_REG, x86_pkg::SEG_SS};
                end
            end
            default: ea = '{x86_pkg::REG_BX, x86_pkg::NO_REG, x86_pkg::SEG_DS}; // rm 111
        endcase
    end

endmodule

`default_nettype wire

//--- disp_decode.sv
`timescale 1ns/1ps
`default_nettype none

module disp_decode (
    input  decode_pkg::decode_ctrl_t ctrl,
    input  x86_pkg::modrm_t          modrm,
    output logic                     need_disp,
    output logic                     disp_size
);

    logic direct;       // mod 00 with rm 110
    logic modrm_disp;
    logic modrm_size;

    assign direct     = (modrm.mod == 2'b00) && (modrm.rm == x86_pkg::RM_DIRECT);
    assign modrm_disp = direct || ^modrm.mod;       // mod 01 or 10
    assign modrm_size = direct || modrm.mod[1];

    always_comb
    begin
        need_disp = 1'b0;
        disp_size = 1'b0;
        case (ctrl.disp_rule)
            decode_pkg::DISP_ALWAYS:
            begin
                need_disp = 1'b1;
                disp_size = ctrl.disp_force16;  // No ModR/M byte to look at
            end
            decode_pkg::DISP_MODRM,
            decode_pkg::DISP_MODRM_MEM:     // Register form never has a displacement
            begin
                need_disp = modrm_disp;
                disp_size = modrm_disp & (ctrl.disp_force16 | modrm_size);
            end
            default:
            begin
                need_disp = 1'b0;
                disp_size = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- opcode_control.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_control (
    input  x86_pkg::opcode_t         opcode,
    output decode_pkg::decode_ctrl_t ctrl
);

    logic listed;   // Opcode has its own row

    // One table row; W and the 16-bit displacement force are filled in later
    function automatic decode_pkg::decode_ctrl_t row(
        input logic                   modrm,
        input decode_pkg::disp_rule_t rule,
        input logic                   imm,
        input logic                   imm16,
        input decode_pkg::opnd_sel_t  dst,
        input decode_pkg::opnd_sel_t  src,
        input logic                   sreg
    );
        decode_pkg::decode_ctrl_t r;
        r            = '0;
        r.need_modrm = modrm;
        r.disp_rule  = rule;
        r.need_imm   = imm;
        r.imm_size   = imm16;
        r.dst_sel    = dst;
        r.src_sel    = src;
        r.sreg_dir   = sreg;
        return r;
    endfunction

    always_comb
    begin
        listed = 1'b1;
        casez (opcode)
            8'b00??_?0??:   // ADD/OR/ADC/SBB/AND/SUB/XOR/CMP R/M R
                ctrl = row(1'b1, decode_pkg::DISP_MODRM, 1'b0, 1'b0,
                           decode_pkg::OPND_DIR_D, decode_pkg::OPND_DIR_S, 1'b0);
            8'b00??_?10?:   // Same ALU ops, ACC IMM
                ctrl = row(1'b0, decode_pkg::DISP_NONE, 1'b1, opcode[0],
                           decode_pkg::OPND_ZERO, decode_pkg::OPND_ZERO, 1'b0);
            8'b0111_????:   // Short conditional branch
                ctrl = row(1'b0, decode_pkg::DISP_ALWAYS, 1'b0, 1'b0,
                           decode_pkg::OPND_ZERO, decode_pkg::OPND_ZERO, 1'b0);
            8'b1000_00??:   // Group 1, only 81 takes a word immediate
                ctrl = row(1'b1, decode_pkg::DISP_MODRM, 1'b1, ~opcode[1] & opcode[0],
                           decode_pkg::OPND_RM, decode_pkg::OPND_ZERO, 1'b0);
            8'b1000_01??:   // TEST and XCHG R/M R
                ctrl = row(1'b1, decode_pkg::DISP_MODRM, 1'b0, 1'b0,
                           decode_pkg::OPND_DIR_D, decode_pkg::OPND_DIR_S, 1'b0);
            8'b1000_10??:   // MOV R/M R
                ctrl = row(1'b1, decode_pkg::DISP_MODRM_MEM, 1'b0, 1'b0,
                           decode_pkg::OPND_DIR_D, decode_pkg::OPND_DIR_S, 1'b0);
            8'b1000_11?0:   // MOV R/M sreg
                ctrl = row(1'b1, decode_pkg::DISP_MODRM_MEM, 1'b0, 1'b0,
                           decode_pkg::OPND_DIR_D, decode_pkg::OPND_DIR_S, 1'b1);
            8'b1000_1101:   // LEA
                ctrl = row(1'b1, decode_pkg::DISP_MODRM, 1'b0, 1'b0,
                           decode_pkg::OPND_DIR_D, decode_pkg::OPND_ZERO, 1'b0);
            8'b1000_1111:   // POP R/M
                ctrl = row(1'b1, decode_pkg::DISP_MODRM, 1'b0, 1'b0,
                           decode_pkg::OPND_RM, decode_pkg::OPND_ZERO, 1'b0);
            8'b1001_0???:   // XCHG ACC, 90 is NOP
                ctrl = row(1'b0, decode_pkg::DISP_NONE, 1'b0, 1'b0,
                           decode_pkg::OPND_ZERO, decode_pkg::OPND_OPC, 1'b0);
            8'b1001_1010,
            8'b1110_1010:   // Far CALL and far JMP, offset then segment
                ctrl = row(1'b0, decode_pkg::DISP_ALWAYS, 1'b1, 1'b1,
                           decode_pkg::OPND_ZERO, decode_pkg::OPND_ZERO, 1'b0);
            8'b1010_00??:   // MOV M ACC
                ctrl = row(1'b0, decode_pkg::DISP_ALWAYS, 1'b0, 1'b0,
                           decode_pkg::OPND_ZERO, decode_pkg::OPND_ZERO, 1'b0);
            8'b1010_100?:   // TEST ACC IMM
                ctrl = row(1'b0, decode_pkg::DISP_NONE, 1'b1, opcode[0],
                           decode_pkg::OPND_ZERO, decode_pkg::OPND_ZERO, 1'b0);
            8'b1011_????:   // MOV R IMM
                ctrl = row(1'b0, decode_pkg::DISP_NONE, 1'b1, opcode[3],
                           decode_pkg::OPND_OPC, decode_pkg::OPND_ZERO, 1'b0);
            8'b1100_000?:   // Shift group with imm8 count
                ctrl = row(1'b1, decode_pkg::DISP_MODRM, 1'b1, 1'b0,
                           decode_pkg::OPND_RM, decode_pkg::OPND_RM, 1'b0);
            8'b1100_010?:   // LES and LDS
                ctrl = row(1'b1, decode_pkg::DISP_MODRM, 1'b0, 1'b0,
                           decode_pkg::OPND_ZERO, decode_pkg::OPND_DIR_S, 1'b0);
            8'b1100_011?:   // MOV IMM to R/M
                ctrl = row(1'b1, decode_pkg::DISP_MODRM, 1'b1, opcode[0],
                           decode_pkg::OPND_RM, decode_pkg::OPND_ZERO, 1'b0);
            default:
            begin
                listed = 1'b0;
                ctrl   = '0;
            end
        endcase

        if (listed)
        begin
            // MOV R IMM and 8C..8F carry W in bit 3
            ctrl.byte_word = (opcode[7:4] == 4'b1011 || opcode[7:2] == 6'b100011) ?
                             opcode[3] : opcode[0];
            ctrl.disp_force16 = opcode[7] & (opcode[5] | opcode[4])
                                & ~(opcode[6] & opcode[4]);
        end
    end

endmodule

`default_nettype wire

//--- decode_pkg.sv
`default_nettype none

package decode_pkg;

    // Where the displacement presence comes from
    typedef enum logic [1:0] {
        DISP_NONE,
        DISP_ALWAYS,
        DISP_MODRM,
        DISP_MODRM_MEM      // ModR/M rule, never for a register operand
    } disp_rule_t;

    // Operand id source
    typedef enum logic [2:0] {
        OPND_ZERO,
        OPND_REGM,
        OPND_RM,
        OPND_DIR_D,         // reg when D is set, else rm
        OPND_DIR_S,         // Opposite of OPND_DIR_D
        OPND_OPC            // Register in opcode bits 2..0
    } opnd_sel_t;

    // Per-opcode control, one table row
    typedef struct packed {
        logic       need_modrm;
        disp_rule_t disp_rule;
        logic       disp_force16;
        logic       need_imm;
        logic       imm_size;       // 1 for a 16-bit immediate
        logic       byte_word;
        opnd_sel_t  dst_sel;
        opnd_sel_t  src_sel;
        logic       sreg_dir;       // MOV to or from a segment register
    } decode_ctrl_t;

    // Effective address parts
    typedef struct packed {
        x86_pkg::reg_id_t base;
        x86_pkg::reg_id_t index;
        x86_pkg::seg_t    seg;
    } ea_t;

    // Registered decode record
    typedef struct packed {
        logic             need_modrm;
        logic             need_disp;
        logic             disp_size;    // 1 for a 16-bit displacement
        logic             need_imm;
        logic             imm_size;
        logic             byte_word;
        x86_pkg::reg_id_t src;
        x86_pkg::reg_id_t dst;
        ea_t              ea;
    } decode_out_t;

endpackage

`default_nettype wire

//--- x86_pkg.sv
`default_nettype none

package x86_pkg;

    typedef logic [7:0] opcode_t;   // First instruction byte

    // Second instruction byte
    typedef struct packed {
        logic [1:0] mod;
        logic [2:0] regm;   // Register number or opcode extension
        logic [2:0] rm;
    } modrm_t;

    // High bit set means a segment register in operand ids,
    // and an unused slot in address ids
    typedef logic [3:0] reg_id_t;

    typedef logic [1:0] seg_t;

    localparam reg_id_t NO_REG = 4'b1100;   // Slot not used in the address
    localparam reg_id_t REG_BX = 4'b0011;
    localparam reg_id_t REG_BP = 4'b0101;
    localparam reg_id_t REG_SI = 4'b0110;
    localparam reg_id_t REG_DI = 4'b0111;

    localparam seg_t SEG_SS = 2'b10;
    localparam seg_t SEG_DS = 2'b11;

    // Direct address when paired with mod 00
    localparam logic [2:0] RM_DIRECT = 3'b110;
    localparam logic [1:0] MOD_REG   = 2'b11;   // Both operands in registers

endpackage

`default_nettype wire
